//--- logic/cpuIsaPkg.sv
package cpuIsaPkg;

  ////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////
  localparam int DataW    = 8;
  localparam int RegAddrW = 4;
  localparam int PcW      = 8;
  localparam int OpcodeW  = 5;
  localparam int NumRegs  = 1 << RegAddrW;

  // I/O port map
  localparam int NumPorts = 4;
  localparam logic [DataW-1:0] InPortBase = 8'hF1; // Port 0, ports 1-3 follow

  typedef logic [DataW-1:0]    data_t;
  typedef logic [RegAddrW-1:0] regAddr_t;
  typedef logic [PcW-1:0]      pc_t;

  // Codes 18-31 are unused and decode as NOP
  typedef enum logic [OpcodeW-1:0] {
    OpNop  = 5'd0,
    OpAdd  = 5'd1,
    OpSub  = 5'd2,
    OpAnd  = 5'd3,
    OpOr   = 5'd4,
    OpXor  = 5'd5,
    OpShl  = 5'd6,
    OpShr  = 5'd7,
    OpAddi = 5'd8,
    OpSubi = 5'd9,
    OpLdi  = 5'd10,
    OpIn   = 5'd11,
    OpOut  = 5'd12,
    OpJmp  = 5'd13,
    OpJz   = 5'd14,
    OpJnz  = 5'd15,
    OpJc   = 5'd16,
    OpJnc  = 5'd17
  } opcode_t;

  // 25-bit instruction word, opcode in the top bits
  typedef struct packed {
    opcode_t  opcode;
    regAddr_t dest;
    regAddr_t src1;
    regAddr_t src2;
    data_t    imm;
  } instr_t;

endpackage

//--- logic/cpuCtrlPkg.sv
package cpuCtrlPkg;

  // One instruction takes five phases
  typedef enum logic [2:0] {
    PhT0, // Fetch
    PhT1, // Register read
    PhT2, // Execute
    PhT3, // Port access
    PhT4  // Write back, PC update
  } phase_t;

  typedef struct packed {
    logic z;
    logic c;
  } flags_t;

  typedef enum logic [2:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluXor,
    AluShl,
    AluShr
  } aluOp_t;

  typedef enum logic [1:0] {
    WbAlu,
    WbImm,
    WbInport
  } wbSel_t;

  ////////////////////////////////////////
  // Control word, strobes then selects
  ////////////////////////////////////////
  typedef struct packed {
    logic   regRead;
    logic   aluSave;
    logic   zSave;
    logic   cSave;
    logic   inRead;
    logic   outWrite;
    logic   regWrite;
    logic   pcStep;  // PC update slot, every T4
    logic   pcLoad;  // Take the jump target at T4
    logic   irLoad;
    aluOp_t aluOp;
    logic   useImm;
    wbSel_t wbSel;
  } ctrl_t;

endpackage

//--- logic/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
  parameter int unsigned ProgDepth = 256
) (
  input  logic               clk,
  input  logic               Reset,
  input  logic               progWrite,
  input  cpuIsaPkg::pc_t     progAddr,
  input  cpuIsaPkg::instr_t  progData,
  input  cpuCtrlPkg::ctrl_t  ctrl,
  output cpuIsaPkg::instr_t  instr,
  output cpuIsaPkg::pc_t     pc
);
  import cpuIsaPkg::*;

  localparam int AddrW = (ProgDepth > 1) ? $clog2(ProgDepth) : 1;

  instr_t progMem [ProgDepth];
  pc_t    pcNext;

  // Program load port, used by the boot loader while the core is held
  always_ff @(posedge clk) begin
    if (progWrite) begin
      progMem[progAddr[AddrW-1:0]] <= progData;
    end
  end

  // Instruction register, resets to NOP
  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      instr <= '0;
    end else if (ctrl.irLoad) begin
      instr <= progMem[pc[AddrW-1:0]];
    end
  end

  assign pcNext = ctrl.pcLoad ? instr.imm : pc + 8'd1; // Jump target or next word

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      pc <= '0;
    end else if (ctrl.pcStep) begin
      pc <= pcNext;
    end
  end

  // Loading a program while the core runs would corrupt the fetch
  progLoadInReset: assert property (
    @(posedge clk) progWrite |-> Reset
  ) else $error("progWrite seen outside Reset");

endmodule

//--- logic/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
  input  logic               clk,
  input  logic               Reset,
  input  cpuIsaPkg::instr_t  instr,
  input  cpuCtrlPkg::flags_t flags,
  output cpuCtrlPkg::ctrl_t  ctrl
);
  import cpuIsaPkg::*;
  import cpuCtrlPkg::*;

  phase_t phase;
  logic   isAlu, setsCarry, readsSrc, writesDest, isIn, isOut, jumpTaken;
  aluOp_t aluOpSel;
  logic   useImmSel;
  wbSel_t wbSelSel;

  // Phase counter wraps after T4
  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      phase <= PhT0;
    end else if (phase == PhT4) begin
      phase <= PhT0;
    end else begin
      phase <= phase_t'(phase + 3'd1);
    end
  end

  ////////////////////////////////////////
  // Opcode classes
  ////////////////////////////////////////
  always_comb begin
    isAlu      = 1'b0;
    setsCarry  = 1'b0;
    isIn       = 1'b0;
    isOut      = 1'b0;
    jumpTaken  = 1'b0;
    aluOpSel   = AluAdd;
    useImmSel  = 1'b0;
    wbSelSel   = WbAlu;
    unique case (instr.opcode)
      OpAdd: begin
        isAlu     = 1'b1;
        setsCarry = 1'b1;
      end
      OpSub: begin
        isAlu     = 1'b1;
        setsCarry = 1'b1;
        aluOpSel  = AluSub;
      end
      OpAnd: begin
        isAlu    = 1'b1;
        aluOpSel = AluAnd;
      end
      OpOr: begin
        isAlu    = 1'b1;
        aluOpSel = AluOr;
      end
      OpXor: begin
        isAlu    = 1'b1;
        aluOpSel = AluXor;
      end
      OpShl: begin
        isAlu     = 1'b1;
        setsCarry = 1'b1;
        aluOpSel  = AluShl;
      end
      OpShr: begin
        isAlu     = 1'b1;
        setsCarry = 1'b1;
        aluOpSel  = AluShr;
      end
      OpAddi: begin
        isAlu     = 1'b1;
        setsCarry = 1'b1;
        useImmSel = 1'b1;
      end
      OpSubi: begin
        isAlu     = 1'b1;
        setsCarry = 1'b1;
        useImmSel = 1'b1;
        aluOpSel  = AluSub;
      end
      OpLdi:  wbSelSel = WbImm;
      OpIn: begin
        isIn     = 1'b1;
        wbSelSel = WbInport;
      end
      OpOut:  isOut = 1'b1;
      OpJmp:  jumpTaken = 1'b1;
      OpJz:   jumpTaken = flags.z;
      OpJnz:  jumpTaken = ~flags.z;
      OpJc:   jumpTaken = flags.c;
      OpJnc:  jumpTaken = ~flags.c;
      default: ; // NOP and unused codes
    endcase
  end

  assign readsSrc   = isAlu | isOut;
  assign writesDest = isAlu | isIn | (instr.opcode == OpLdi);

  // Strobes live for exactly one phase
  always_comb begin
    ctrl          = '0;
    ctrl.aluOp    = aluOpSel;
    ctrl.useImm   = useImmSel;
    ctrl.wbSel    = wbSelSel;
    ctrl.irLoad   = (phase == PhT0) & ~Reset; // Held core fetches nothing
    ctrl.regRead  = (phase == PhT1) & readsSrc;
    ctrl.aluSave  = (phase == PhT2) & isAlu;
    ctrl.zSave    = (phase == PhT2) & isAlu;
    ctrl.cSave    = (phase == PhT2) & setsCarry;
    ctrl.inRead   = (phase == PhT3) & isIn;
    ctrl.outWrite = (phase == PhT3) & isOut;
    ctrl.regWrite = (phase == PhT4) & writesDest;
    ctrl.pcStep   = (phase == PhT4);
    ctrl.pcLoad   = (phase == PhT4) & jumpTaken;
  end

  phaseLegal: assert property (
    @(posedge clk) disable iff (Reset)
    phase inside {PhT0, PhT1, PhT2, PhT3, PhT4}
  ) else $error("Phase left T0-T4");

  noReadWriteOverlap: assert property (
    @(posedge clk) disable iff (Reset) !(ctrl.regWrite && ctrl.regRead)
  ) else $error("regWrite and regRead in the same cycle");

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic               clk,
  input  logic               Reset,
  input  cpuCtrlPkg::ctrl_t  ctrl,
  input  cpuIsaPkg::instr_t  instr,
  input  cpuIsaPkg::data_t   wbData,
  output cpuIsaPkg::data_t   rdData1,
  output cpuIsaPkg::data_t   rdData2
);
  import cpuIsaPkg::*;

  data_t regs [NumRegs];

  ////////////////////////////////////////
  // Write port, dest at T4
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      regs <= '{default: '0};
    end else if (ctrl.regWrite) begin
      regs[instr.dest] <= wbData;
    end
  end

  // Read latches hold both sources until the next T1
  always_ff @(posedge clk) begin
    if (ctrl.regRead) begin
      rdData1 <= regs[instr.src1];
      rdData2 <= regs[instr.src2];
    end
  end

  // Read data must be valid when the ALU result is saved
  readBeforeExec: assert property (
    @(posedge clk) disable iff (Reset)
    ctrl.aluSave |-> $past(ctrl.regRead)
  ) else $error("ALU saved without a preceding register read");

endmodule

//--- logic/aluExecute.sv
`timescale 1ns/1ps

module aluExecute (
  input  logic               clk,
  input  logic               Reset,
  input  cpuCtrlPkg::ctrl_t  ctrl,
  input  cpuIsaPkg::data_t   rdData1,
  input  cpuIsaPkg::data_t   rdData2,
  input  cpuIsaPkg::data_t   imm,
  output cpuIsaPkg::data_t   aluResult,
  output cpuCtrlPkg::flags_t flags
);
  import cpuIsaPkg::*;
  import cpuCtrlPkg::*;

  localparam int ShW = $clog2(DataW);

  data_t            opB;
  data_t            result;
  logic             carry;
  logic [DataW:0]   wide;   // Sum or difference with carry bit
  logic [ShW-1:0]   shAmt;

  assign opB   = ctrl.useImm ? imm : rdData2;
  assign shAmt = opB[ShW-1:0];

  ////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////
  always_comb begin
    wide   = '0;
    result = '0;
    carry  = 1'b0;
    unique case (ctrl.aluOp)
      AluAdd: begin
        wide   = {1'b0, rdData1} + {1'b0, opB};
        result = wide[DataW-1:0];
        carry  = wide[DataW];
      end
      AluSub: begin
        wide   = {1'b0, rdData1} - {1'b0, opB};
        result = wide[DataW-1:0];
        carry  = ~wide[DataW]; // No borrow
      end
      AluAnd: result = rdData1 & opB;
      AluOr:  result = rdData1 | opB;
      AluXor: result = rdData1 ^ opB;
      AluShl: begin
        result = rdData1 << shAmt;
        carry  = (shAmt != '0) & rdData1[DataW-1];
      end
      AluShr: begin
        result = rdData1 >> shAmt;
        carry  = (shAmt != '0) & rdData1[0];
      end
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      aluResult <= '0;
      flags     <= '0;
    end else begin
      if (ctrl.aluSave) aluResult <= result;
      if (ctrl.zSave)   flags.z   <= (result == '0);
      if (ctrl.cSave)   flags.c   <= carry;
    end
  end

  // Any op that touches C also saves its result and Z
  carryWithResult: assert property (
    @(posedge clk) disable iff (Reset) ctrl.cSave |-> (ctrl.zSave && ctrl.aluSave)
  ) else $error("Carry saved without result and Z");

endmodule

//--- logic/resultStage.sv
`timescale 1ns/1ps

module resultStage (
  input  logic               clk,
  input  logic               Reset,
  input  cpuCtrlPkg::ctrl_t  ctrl,
  input  cpuIsaPkg::data_t   imm,
  input  cpuIsaPkg::data_t   aluResult,
  input  cpuIsaPkg::data_t   rdData1,
  input  cpuIsaPkg::data_t   inPorts  [cpuIsaPkg::NumPorts],
  output cpuIsaPkg::data_t   wbData,
  output cpuIsaPkg::data_t   outPorts [cpuIsaPkg::NumPorts]
);
  import cpuIsaPkg::*;
  import cpuCtrlPkg::*;

  localparam int PortIdxW = $clog2(NumPorts);

  data_t                inSample [NumPorts];
  data_t                inLatch;
  data_t                portOffset;
  logic [PortIdxW-1:0]  inSel;

  always_ff @(posedge clk) begin
    inSample <= inPorts; // Sampled every cycle
  end

  // 0xF1-0xF4 map to ports 0-3, anything else reads port 0
  assign portOffset = imm - InPortBase;
  assign inSel      = (portOffset < data_t'(NumPorts)) ? portOffset[PortIdxW-1:0] : '0;

  always_ff @(posedge clk) begin
    if (ctrl.inRead) begin
      inLatch <= inSample[inSel];
    end
  end

  ////////////////////////////////////////
  // Write-back select
  ////////////////////////////////////////
  always_comb begin
    unique case (ctrl.wbSel)
      WbImm:    wbData = imm;
      WbInport: wbData = inLatch;
      default:  wbData = aluResult;
    endcase
  end

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      outPorts <= '{default: '0};
    end else if (ctrl.outWrite) begin
      outPorts[imm[PortIdxW-1:0]] <= rdData1;
    end
  end

  // IN writes back the port value latched one phase earlier
  inLatchedFirst: assert property (
    @(posedge clk) disable iff (Reset)
    (ctrl.regWrite && ctrl.wbSel == WbInport) |-> $past(ctrl.inRead)
  ) else $error("Input port written back without a latch");

endmodule

//--- logic/cpuCore.sv
`timescale 1ns/1ps

module cpuCore #(
  parameter int unsigned ProgDepth = 256
) (
  input  logic               clk,
  input  logic               Reset,
  input  logic               progWrite,
  input  cpuIsaPkg::pc_t     progAddr,
  input  cpuIsaPkg::instr_t  progData,
  input  cpuIsaPkg::data_t   inPorts  [cpuIsaPkg::NumPorts],
  output cpuIsaPkg::data_t   outPorts [cpuIsaPkg::NumPorts],
  output cpuIsaPkg::pc_t     pc,
  output cpuCtrlPkg::flags_t flags
);
  import cpuIsaPkg::*;
  import cpuCtrlPkg::*;

  ctrl_t  ctrl;
  instr_t instr;
  data_t  rdData1, rdData2;
  data_t  aluResult;
  data_t  wbData;

  ////////////////////////////////////////
  // Units
  ////////////////////////////////////////
  fetchUnit #(.ProgDepth(ProgDepth)) fetch (
    .clk(clk), .Reset(Reset), .progWrite(progWrite), .progAddr(progAddr),
    .progData(progData), .ctrl(ctrl), .instr(instr), .pc(pc)
  );

  instrDecode decode (
    .clk(clk), .Reset(Reset), .instr(instr), .flags(flags), .ctrl(ctrl)
  );

  regFile regs (
    .clk(clk), .Reset(Reset), .ctrl(ctrl), .instr(instr), .wbData(wbData),
    .rdData1(rdData1), .rdData2(rdData2)
  );

  aluExecute alu (
    .clk(clk), .Reset(Reset), .ctrl(ctrl), .rdData1(rdData1), .rdData2(rdData2),
    .imm(instr.imm), .aluResult(aluResult), .flags(flags)
  );

  resultStage result (
    .clk(clk), .Reset(Reset), .ctrl(ctrl), .imm(instr.imm), .aluResult(aluResult),
    .rdData1(rdData1), .inPorts(inPorts), .wbData(wbData), .outPorts(outPorts)
  );

endmodule

//--- include/cpuRefModel.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Architectural state stepped once per instruction
typedef struct {
  cpuIsaPkg::data_t   regs     [cpuIsaPkg::NumRegs];
  cpuIsaPkg::data_t   inPorts  [cpuIsaPkg::NumPorts];
  cpuIsaPkg::data_t   outPorts [cpuIsaPkg::NumPorts];
  cpuIsaPkg::pc_t     pc;
  cpuCtrlPkg::flags_t flags;
} refState_t;

// Input port values survive reset
function automatic refState_t resetModel(refState_t s);
  refState_t n;
  n = s;
  foreach (n.regs[i])
    n.regs[i] = '0;
  foreach (n.outPorts[i])
    n.outPorts[i] = '0;
  n.pc    = '0;
  n.flags = '0;
  return n;
endfunction

function automatic refState_t stepModel(refState_t s, cpuIsaPkg::instr_t ins);
  refState_t        n;
  cpuIsaPkg::data_t a;
  cpuIsaPkg::data_t b;
  cpuIsaPkg::data_t r;
  logic [8:0]       wide;
  logic             isAlu;
  n     = s;
  a     = s.regs[ins.src1];
  b     = (ins.opcode inside {cpuIsaPkg::OpAddi, cpuIsaPkg::OpSubi}) ? ins.imm : s.regs[ins.src2];
  r     = '0;
  isAlu = 1'b1;
  n.pc  = s.pc + 8'd1;
  case (ins.opcode)
    cpuIsaPkg::OpAdd, cpuIsaPkg::OpAddi: begin
      wide      = {1'b0, a} + {1'b0, b};
      r         = wide[7:0];
      n.flags.c = wide[8];
    end
    cpuIsaPkg::OpSub, cpuIsaPkg::OpSubi: begin
      r         = a - b;
      n.flags.c = (a >= b); // No borrow
    end
    cpuIsaPkg::OpAnd: r = a & b;
    cpuIsaPkg::OpOr:  r = a | b;
    cpuIsaPkg::OpXor: r = a ^ b;
    cpuIsaPkg::OpShl: begin
      r         = a << b[2:0];
      n.flags.c = (b[2:0] != 3'd0) & a[7];
    end
    cpuIsaPkg::OpShr: begin
      r         = a >> b[2:0];
      n.flags.c = (b[2:0] != 3'd0) & a[0];
    end
    default: isAlu = 1'b0;
  endcase
  case (ins.opcode)
    cpuIsaPkg::OpLdi: n.regs[ins.dest] = ins.imm;
    cpuIsaPkg::OpIn: begin
      case (ins.imm)
        8'hF2:   n.regs[ins.dest] = s.inPorts[1];
        8'hF3:   n.regs[ins.dest] = s.inPorts[2];
        8'hF4:   n.regs[ins.dest] = s.inPorts[3];
        default: n.regs[ins.dest] = s.inPorts[0]; // 0xF1 and every other address
      endcase
    end
    cpuIsaPkg::OpOut: n.outPorts[ins.imm[1:0]] = a;
    cpuIsaPkg::OpJmp: n.pc = ins.imm;
    cpuIsaPkg::OpJz:  if (s.flags.z) n.pc = ins.imm;
    cpuIsaPkg::OpJnz: if (!s.flags.z) n.pc = ins.imm;
    cpuIsaPkg::OpJc:  if (s.flags.c) n.pc = ins.imm;
    cpuIsaPkg::OpJnc: if (!s.flags.c) n.pc = ins.imm;
    default: ;
  endcase
  if (isAlu) begin
    n.regs[ins.dest] = r;
    n.flags.z        = (r == 8'd0);
  end
  return n;
endfunction

// Random word with jumps inside the loaded program
function automatic cpuIsaPkg::instr_t randomInstr(int unsigned progLen);
  cpuIsaPkg::instr_t ins;
  ins.opcode = cpuIsaPkg::opcode_t'($urandom_range(0, 19));
  ins.dest   = 4'($urandom);
  ins.src1   = 4'($urandom);
  ins.src2   = 4'($urandom);
  ins.imm    = 8'($urandom);
  if (ins.opcode inside {[cpuIsaPkg::OpJmp:cpuIsaPkg::OpJnc]})
    ins.imm = 8'($urandom_range(0, progLen - 1));
  else if (ins.opcode == cpuIsaPkg::OpIn)
    ins.imm = 8'($urandom_range(8'hF0, 8'hF5)); // Around the port window
  return ins;
endfunction

`endif

//--- sim/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb;
  import cpuIsaPkg::*;
  import cpuCtrlPkg::*;

  `include "cpuRefModel.svh"

  localparam int NumProgs  = 8;
  localparam int ProgLen   = 64;   // Random words per program
  localparam int ProgDepth = 256;
  localparam int NumInstr  = 100;
  localparam int ResetHold = 4;
  // Load, reset hold and five cycles per instruction, plus 10% margin
  localparam int TimeoutCycles =
    NumProgs * (ProgDepth + ResetHold + 5 * NumInstr + 2) * 11 / 10;

  logic      clk;
  logic      Reset;
  logic      progWrite;
  pc_t       progAddr;
  instr_t    progData;
  data_t     inPorts  [NumPorts];
  data_t     outPorts [NumPorts];
  pc_t       pc;
  flags_t    flags;

  instr_t    prog [ProgDepth];  // Copy of what the DUT memory holds
  refState_t model;
  int        checkCount;
  int        errorCount;
  int        progErrors;
  int        cycleCount;

  cpuCore #(.ProgDepth(ProgDepth)) uut (
    .clk(clk), .Reset(Reset), .progWrite(progWrite), .progAddr(progAddr),
    .progData(progData), .inPorts(inPorts), .outPorts(outPorts), .pc(pc), .flags(flags)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic checkData(input string name, input data_t expected, input data_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      progErrors++;
      $display("FAILED %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
    end
  endtask

  task automatic checkPc(input string name, input pc_t expected, input pc_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      progErrors++;
      $display("FAILED %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
    end
  endtask

  task automatic checkFlags(input string name, input flags_t expected, input flags_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      progErrors++;
      $display("FAILED %s: expected z=%b c=%b, actual z=%b c=%b",
               name, expected.z, expected.c, actual.z, actual.c);
    end
  endtask

  task automatic compareState(input string name);
    checkPc({name, " pc"}, model.pc, pc);
    checkFlags({name, " flags"}, model.flags, flags);
    for (int i = 0; i < NumPorts; i++) begin
      checkData($sformatf("%s out%0d", name, i), model.outPorts[i], outPorts[i]);
    end
  endtask

  // Inputs change just after the rising edge
  task automatic stepClock();
    @(posedge clk);
    #1;
  endtask

  // NOP words above the random part for a PC that runs past it
  function automatic instr_t idleWord(pc_t addr);
    instr_t w;
    w.opcode = OpNop;
    w.dest   = addr[7:4];
    w.src1   = addr[3:0];
    w.src2   = addr[7:4] ^ addr[3:0];
    w.imm    = addr;
    return w;
  endfunction

  ////////////////////////////////////////
  // One program, load then run
  ////////////////////////////////////////
  task automatic loadProgram();
    for (int a = 0; a < ProgDepth; a++) begin
      prog[a]   = (a < ProgLen) ? randomInstr(ProgLen) : idleWord(pc_t'(a));
      progWrite = 1'b1;
      progAddr  = pc_t'(a);
      progData  = prog[a];
      stepClock();
    end
    progWrite = 1'b0;
  endtask

  task automatic runProgram(input int p);
    instr_t ins;
    progErrors = 0;
    Reset      = 1'b1;
    loadProgram();
    foreach (inPorts[i]) begin
      inPorts[i] = data_t'($urandom);
    end
    model.inPorts = inPorts;
    model         = resetModel(model);
    repeat (ResetHold) stepClock();
    compareState($sformatf("prog%0d reset", p)); // Zero state while held
    Reset = 1'b0;
    for (int k = 0; k < NumInstr; k++) begin
      ins   = prog[model.pc];
      model = stepModel(model, ins);
      repeat (5) @(posedge clk); // Instruction ends at its T4 edge
      #1;
      compareState($sformatf("prog%0d instr%0d", p, k));
    end
    $display("Program %0d: %0d errors, %s", p, progErrors, (progErrors == 0) ? "PASS" : "FAIL");
  endtask

  initial begin
    clk        = 1'b0;
    Reset      = 1'b1;
    progWrite  = 1'b0;
    progAddr   = '0;
    progData   = '0;
    foreach (inPorts[i]) begin
      inPorts[i] = '0;
    end
    checkCount = 0;
    errorCount = 0;
    progErrors = 0;
    void'($urandom(32'h86e0));
    stepClock();
    for (int p = 0; p < NumProgs; p++) begin
      runProgram(p);
    end
    $display("Programs: %0d, checks: %0d, errors: %0d", NumProgs, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Test failed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+include
logic/cpuIsaPkg.sv
logic/cpuCtrlPkg.sv
logic/fetchUnit.sv
logic/instrDecode.sv
logic/regFile.sv
logic/aluExecute.sv
logic/resultStage.sv
logic/cpuCore.sv
sim/cpuCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpuCoreTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
